// ==== Bender.yml ====
package:
  name: music_player

sources:
  - rtl/music_pkg.sv
  - rtl/song_rom.sv
  - rtl/beat_gen.sv
  - rtl/note_player.sv
  - rtl/song_reader.sv
  - rtl/music_player.sv
  - target: simulation
    files:
      - dv/tb_music_player.sv

// ==== dv/tb_music_player.sv ====
`timescale 1ns/1ps

module tb_music_player import music_pkg::*; ();

    localparam int BEAT_CYCLES    = 6;
    localparam int TONE_BASE      = 4;
    // four whole songs at the longest note length, plus slack for resets and pauses
    localparam int TIMEOUT_CYCLES = 4 * 32 * 3 * BEAT_CYCLES + 600;

    logic      clk;
    logic      rst;
    logic      play;
    song_idx_t song;
    logic      song_done;
    logic      new_note;
    note_t     note;
    duration_t duration;
    logic      note_active;
    logic      tone;

    int          cycles;
    int          half_checks;
    logic [15:0] lfsr_q;

    music_player #(.BEAT_CYCLES(BEAT_CYCLES), .TONE_BASE(TONE_BASE)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles without finishing the tests", cycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // helpers and reference model
    // ----------------------------------------
    // taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int val);
        int k;
        val = 0;
        for (k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = (val << 1) | lfsr_q[0];
        end
    endtask

    function automatic int model_note(input int s, input int i);
        int n;
        if (i % 8 == 7) begin
            return 0;
        end
        n = (16 * s + 5 * i + 1) % 64;
        return (n == 0) ? 1 : n;
    endfunction

    function automatic int model_duration(input int i);
        return (i % 3) + 1;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s (got %0d, expected %0d)", $time, msg, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch");
        end
    endtask

    // inputs change 2 ns after the edge, outputs are read at the same point
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rst  = 1'b1;
        play = 1'b0;
        repeat (5) next_cycle();
        rst = 1'b0;
    endtask

    task automatic wait_new_note(output int dones);
        dones = 0;
        while (!new_note) begin
            if (song_done) begin
                dones++;
            end
            next_cycle();
        end
    endtask

    task automatic hold_pause(input song_idx_t resume_song);
        int k;
        play = 1'b0;
        for (k = 0; k < 4; k++) begin
            next_cycle();
            check_eq(new_note, 0, "new_note while paused");
            check_eq(tone, 0, "tone while paused");
            check_eq(note_active, 1, "note_active held while paused");
            if (k == 1) begin
                song = resume_song;
            end
        end
        play = 1'b1;
    endtask

    // called on the new_note cycle, returns once note_active falls or after a pause
    task automatic play_note(input int idx, input int pause_at, input song_idx_t resume_song,
                             output bit paused);
        int   exp_note;
        int   half;
        int   t;
        int   last_edge;
        logic prev_tone;
        exp_note  = model_note(song, idx);
        half      = TONE_BASE + 63 - exp_note;
        paused    = 1'b0;
        t         = 0;
        last_edge = -1;
        prev_tone = tone;
        check_eq(note, exp_note, $sformatf("note of song %0d index %0d", song, idx));
        check_eq(duration, model_duration(idx), $sformatf("duration of index %0d", idx));
        do begin
            next_cycle();
            t++;
            check_eq(new_note, 0, "new_note inside a note");
            if (exp_note == 0) begin
                check_eq(tone, 0, "tone during a rest");
            end
            if (tone != prev_tone) begin
                if (last_edge >= 0) begin
                    check_eq(t - last_edge, half, "tone half period");
                    half_checks++;
                end
                last_edge = t;
            end
            prev_tone = tone;
            if (t == pause_at) begin
                hold_pause(resume_song);
                paused = 1'b1;
                return;
            end
        end while (note_active);
        check_eq(t >= (model_duration(idx) - 1) * BEAT_CYCLES + 1 &&
                 t <= model_duration(idx) * BEAT_CYCLES, 1,
                 $sformatf("length %0d clocks of index %0d", t, idx));
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_idle();
        apply_reset();
        repeat (20) begin
            next_cycle();
            check_eq({new_note, song_done, note_active, tone}, 0, "outputs low while idle");
        end
    endtask

    task automatic test_full_song();
        int s;
        int idx;
        int dones;
        bit paused;
        apply_reset();
        take_bits(2, s);
        song = s;
        play = 1'b1;
        for (idx = 0; idx < 32; idx++) begin
            wait_new_note(dones);
            check_eq(dones, 0, "song_done inside the song");
            play_note(idx, 0, song, paused);
        end
        // wrap back to the first note of the same song
        wait_new_note(dones);
        check_eq(dones, 1, "song_done cycles after index 31");
        play_note(0, 0, song, paused);
        play = 1'b0;
    endtask

    // song 1 index 22 holds note 63, short enough in period for several tone edges
    task automatic test_tone();
        int idx;
        int dones;
        bit paused;
        bit done_pause;
        apply_reset();
        song        = 2'd1;
        play        = 1'b1;
        half_checks = 0;
        idx         = 0;
        done_pause  = 1'b0;
        while (idx <= 22) begin
            wait_new_note(dones);
            check_eq(dones, 0, "song_done inside the song");
            // pause once tone has gone high on the last note
            play_note(idx, (idx == 22 && !done_pause) ? 6 : 0, song, paused);
            if (paused) begin
                done_pause = 1'b1;
            end else begin
                idx++;
            end
        end
        check_eq(done_pause, 1, "pause while tone runs");
        check_eq(half_checks > 0, 1, "tone half period measured");
        play = 1'b0;
    endtask

    task automatic test_pause(input bit switch_song);
        int s;
        int x;
        int p;
        int at;
        int idx;
        int dones;
        bit paused;
        bit done_pause;
        apply_reset();
        take_bits(2, s);
        take_bits(2, x);
        take_bits(2, p);
        take_bits(2, at);
        // two beat notes only, so the pause point always falls inside the note
        p          = 3 * p + 1;
        at         = at + 1;
        song       = s;
        play       = 1'b1;
        idx        = 0;
        done_pause = 1'b0;
        while (idx <= p + 2) begin
            wait_new_note(dones);
            check_eq(dones, 0, "song_done inside the song");
            play_note(idx, (idx == p && !done_pause) ? at : 0,
                      switch_song ? song_idx_t'((s + 1 + x % 3) % 4) : song_idx_t'(s), paused);
            if (paused) begin
                done_pause = 1'b1;
            end else begin
                idx++;
            end
        end
        check_eq(done_pause, 1, "pause point reached");
        play = 1'b0;
    endtask

    initial begin
        rst         = 1'b1;
        play        = 1'b0;
        song        = '0;
        cycles      = 0;
        half_checks = 0;
        lfsr_q      = 16'd69;
        test_idle();
        test_full_song();
        test_tone();
        test_pause(1'b0);
        test_pause(1'b1);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/music_pkg.sv
rtl/song_rom.sv
rtl/beat_gen.sv
rtl/note_player.sv
rtl/song_reader.sv
rtl/music_player.sv
dv/tb_music_player.sv

// ==== rtl/beat_gen.sv ====
`timescale 1ns/1ps

module beat_gen #(
    parameter int BEAT_CYCLES = 1000
) (
    input  logic clk,
    input  logic rst,
    input  logic play,
    output logic beat
);

    localparam int CNT_W = (BEAT_CYCLES > 1) ? $clog2(BEAT_CYCLES) : 1;

    logic [CNT_W-1:0] cnt;

    // restarts from zero every time play goes low
    always_ff @(posedge clk) begin
        if (rst || !play) begin
            cnt  <= '0;
            beat <= 1'b0;
        end else if (cnt == CNT_W'(BEAT_CYCLES - 1)) begin
            cnt  <= '0;
            beat <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            beat <= 1'b0;
        end
    end

    // strobe never stretches past one clock
    a_beat_single: assert property (@(posedge clk) disable iff (rst)
        (BEAT_CYCLES > 1) && beat |=> !beat);

endmodule

// ==== rtl/music_pkg.sv ====
package music_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int SONG_W     = 2;
    localparam int NOTE_NUM_W = 5;
    localparam int ROM_ADDR_W = SONG_W + NOTE_NUM_W;

    // note word holds the timed flag, note, duration and three spare bits
    localparam int NOTE_LSB = 9;
    localparam int DUR_LSB  = 3;

    typedef logic [5:0]            note_t;
    typedef logic [5:0]            duration_t;
    typedef logic [15:0]           rom_word_t;
    typedef logic [SONG_W-1:0]     song_idx_t;
    typedef logic [NOTE_NUM_W-1:0] note_idx_t;

    // ----------------------------------------
    // reader fsm
    // ----------------------------------------
    typedef enum logic [2:0] {
        PAUSED            = 3'b000,
        WAIT_NOTE         = 3'b001,
        INCREMENT_ADDRESS = 3'b010,
        RETRIEVE_NOTE     = 3'b011,
        NEW_NOTE_READY    = 3'b100
    } reader_state_t;

endpackage

// ==== rtl/music_player.sv ====
`timescale 1ns/1ps

module music_player import music_pkg::*; #(
    parameter int BEAT_CYCLES = 1000,
    parameter int TONE_BASE   = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      play,
    input  song_idx_t song,
    output logic      song_done,
    output logic      new_note,
    output note_t     note,
    output duration_t duration,
    output logic      note_active,
    output logic      tone
);

    logic [ROM_ADDR_W-1:0] rom_addr;
    rom_word_t             rom_word;
    logic                  beat;
    logic                  note_done;

    song_reader reader_i (
        .clk       (clk),
        .rst       (rst),
        .play      (play),
        .song      (song),
        .note_done (note_done),
        .rom_word  (rom_word),
        .rom_addr  (rom_addr),
        .new_note  (new_note),
        .song_done (song_done),
        .note      (note),
        .duration  (duration)
    );

    song_rom rom_i (
        .clk  (clk),
        .addr (rom_addr),
        .dout (rom_word)
    );

    beat_gen #(.BEAT_CYCLES(BEAT_CYCLES)) beat_i (
        .clk  (clk),
        .rst  (rst),
        .play (play),
        .beat (beat)
    );

    note_player #(.TONE_BASE(TONE_BASE)) player_i (
        .clk         (clk),
        .rst         (rst),
        .play        (play),
        .beat        (beat),
        .new_note    (new_note),
        .note        (note),
        .duration    (duration),
        .note_done   (note_done),
        .note_active (note_active),
        .tone        (tone)
    );

endmodule

// ==== rtl/note_player.sv ====
`timescale 1ns/1ps

module note_player import music_pkg::*; #(
    parameter int TONE_BASE = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      play,
    input  logic      beat,
    input  logic      new_note,
    input  note_t     note,
    input  duration_t duration,
    output logic      note_done,
    output logic      note_active,
    output logic      tone
);

    localparam int TONE_W = $clog2(TONE_BASE + 64);

    duration_t        beats_left;
    duration_t        cnt_base;
    duration_t        cnt_next;
    logic             step;
    logic             tone_en;
    logic [TONE_W-1:0] half_period;
    logic [TONE_W-1:0] tone_cnt;

    // ----------------------------------------
    // beat countdown
    // ----------------------------------------
    assign step = beat && play;

    // a beat landing with new_note already counts toward the new note
    always_comb begin
        cnt_base = new_note ? duration : beats_left;
        cnt_next = cnt_base;
        if (step && cnt_base != '0) begin
            cnt_next = cnt_base - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
            note_done  <= 1'b0;
        end else begin
            beats_left <= cnt_next;
            note_done  <= (cnt_base != '0) && (cnt_next == '0);
        end
    end

    assign note_active = (beats_left != '0);

    // ----------------------------------------
    // tone divider
    // ----------------------------------------
    // higher note number gives a shorter half period
    assign half_period = TONE_W'(TONE_BASE) + TONE_W'(6'd63 - note);
    assign tone_en     = note_active && play && (note != '0);

    always_ff @(posedge clk) begin
        if (rst || !tone_en) begin
            tone_cnt <= '0;
            tone     <= 1'b0;
        end else if (tone_cnt == half_period - 1'b1) begin
            tone_cnt <= '0;
            tone     <= ~tone;
        end else begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        note_done |=> !note_done);

    // one clock of slack while the divider clears after a note change
    a_rest_quiet: assert property (@(posedge clk) disable iff (rst)
        (note == '0) && $past(note == '0) |-> !tone);

endmodule

// ==== rtl/song_reader.sv ====
`timescale 1ns/1ps

module song_reader import music_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  play,
    input  song_idx_t             song,
    input  logic                  note_done,
    input  rom_word_t             rom_word,
    output logic [ROM_ADDR_W-1:0] rom_addr,
    output logic                  new_note,
    output logic                  song_done,
    output note_t                 note,
    output duration_t             duration
);

    reader_state_t state;
    reader_state_t state_next;
    note_idx_t     idx;
    note_idx_t     idx_inc;
    logic          idx_carry;
    note_t         rom_note;
    duration_t     rom_dur;
    note_t         note_q;
    duration_t     dur_q;

    // ----------------------------------------
    // note index
    // ----------------------------------------
    assign {idx_carry, idx_inc} = {1'b0, idx} + 1'b1;
    assign rom_addr  = {song, idx};
    assign song_done = (state == INCREMENT_ADDRESS) && idx_carry;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (state == INCREMENT_ADDRESS) begin
            idx <= idx_inc;
        end
    end

    // ----------------------------------------
    // state machine
    // ----------------------------------------
    always_comb begin
        case (state)
            PAUSED:            state_next = play ? RETRIEVE_NOTE : PAUSED;
            RETRIEVE_NOTE:     state_next = play ? NEW_NOTE_READY : PAUSED;
            NEW_NOTE_READY:    state_next = play ? WAIT_NOTE : PAUSED;
            WAIT_NOTE:         state_next = !play     ? PAUSED :
                                            note_done ? INCREMENT_ADDRESS : WAIT_NOTE;
            // end of song always parks, play restarts from index 0
            INCREMENT_ADDRESS: state_next = (play && !idx_carry) ? RETRIEVE_NOTE : PAUSED;
            default:           state_next = PAUSED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PAUSED;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------
    // note fields
    // ----------------------------------------
    assign rom_note = rom_word[NOTE_LSB +: $bits(note_t)];
    assign rom_dur  = rom_word[DUR_LSB +: $bits(duration_t)];
    assign new_note = (state == NEW_NOTE_READY);

    // held copy keeps the outputs steady once the address moves on
    always_ff @(posedge clk) begin
        if (new_note) begin
            note_q <= rom_note;
            dur_q  <= rom_dur;
        end
    end

    assign note     = new_note ? rom_note : note_q;
    assign duration = new_note ? rom_dur : dur_q;

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_strobe_after_fetch: assert property (@(posedge clk) disable iff (rst)
        new_note |-> $past(state) == RETRIEVE_NOTE);

    a_done_parks: assert property (@(posedge clk) disable iff (rst)
        song_done |-> (state == INCREMENT_ADDRESS) ##1 (state == PAUSED));

endmodule

// ==== rtl/song_rom.sv ====
`timescale 1ns/1ps

module song_rom import music_pkg::*; (
    input  logic                  clk,
    input  logic [ROM_ADDR_W-1:0] addr,
    output rom_word_t             dout
);

    song_idx_t song_sel;
    note_idx_t note_sel;

    assign song_sel = addr[ROM_ADDR_W-1 -: SONG_W];
    assign note_sel = addr[NOTE_NUM_W-1:0];

    // ----------------------------------------
    // note tables, one per song
    // ----------------------------------------
    // duration cycles 1,2,3 and every eighth slot is a rest
    localparam rom_word_t SONG0 [32] = '{
        16'h8208, 16'h8C10, 16'h9618, 16'hA008, 16'hAA10, 16'hB418, 16'hBE08, 16'h8010,
        16'hD218, 16'hDC08, 16'hE610, 16'hF018, 16'hFA08, 16'h8410, 16'h8E18, 16'h8008,
        16'hA210, 16'hAC18, 16'hB608, 16'hC010, 16'hCA18, 16'hD408, 16'hDE10, 16'h8018,
        16'hF208, 16'hFC10, 16'h8618, 16'h9008, 16'h9A10, 16'hA418, 16'hAE08, 16'h8010
    };

    localparam rom_word_t SONG1 [32] = '{
        16'hA208, 16'hAC10, 16'hB618, 16'hC008, 16'hCA10, 16'hD418, 16'hDE08, 16'h8010,
        16'hF218, 16'hFC08, 16'h8610, 16'h9018, 16'h9A08, 16'hA410, 16'hAE18, 16'h8008,
        16'hC210, 16'hCC18, 16'hD608, 16'hE010, 16'hEA18, 16'hF408, 16'hFE10, 16'h8018,
        16'h9208, 16'h9C10, 16'hA618, 16'hB008, 16'hBA10, 16'hC418, 16'hCE08, 16'h8010
    };

    // slot 19 wraps to note 0, bumped up to 1 so it stays audible
    localparam rom_word_t SONG2 [32] = '{
        16'hC208, 16'hCC10, 16'hD618, 16'hE008, 16'hEA10, 16'hF418, 16'hFE08, 16'h8010,
        16'h9218, 16'h9C08, 16'hA610, 16'hB018, 16'hBA08, 16'hC410, 16'hCE18, 16'h8008,
        16'hE210, 16'hEC18, 16'hF608, 16'h8210, 16'h8A18, 16'h9408, 16'h9E10, 16'h8018,
        16'hB208, 16'hBC10, 16'hC618, 16'hD008, 16'hDA10, 16'hE418, 16'hEE08, 16'h8010
    };

    localparam rom_word_t SONG3 [32] = '{
        16'hE208, 16'hEC10, 16'hF618, 16'h8208, 16'h8A10, 16'h9418, 16'h9E08, 16'h8010,
        16'hB218, 16'hBC08, 16'hC610, 16'hD018, 16'hDA08, 16'hE410, 16'hEE18, 16'h8008,
        16'h8210, 16'h8C18, 16'h9608, 16'hA010, 16'hAA18, 16'hB408, 16'hBE10, 16'h8018,
        16'hD208, 16'hDC10, 16'hE618, 16'hF008, 16'hFA10, 16'h8418, 16'h8E08, 16'h8010
    };

    // ----------------------------------------
    // registered read, one cycle latency
    // ----------------------------------------
    always_ff @(posedge clk) begin
        case (song_sel)
            2'd0:    dout <= SONG0[note_sel];
            2'd1:    dout <= SONG1[note_sel];
            2'd2:    dout <= SONG2[note_sel];
            default: dout <= SONG3[note_sel];
        endcase
    end

endmodule
